// ==== dram_pkg.sv ====
/* Memory subsystem shared definitions
   Bus widths, memory geometry and the enums used across the blocks */

package dram_pkg;

  //////////////////////////////
  // SoC side
  //////////////////////////////
  localparam int SocDataWidth = 32;
  localparam int SocStrbWidth = SocDataWidth / 8;
  localparam int SocAddrWidth = 32;
  localparam int SocIdWidth   = 4;

  //////////////////////////////
  // Memory side
  //////////////////////////////
  localparam int DramDataWidth = 128;
  localparam int DramStrbWidth = DramDataWidth / 8;
  localparam int DramAddrWidth = 12;
  localparam int DramDepth     = 256;
  localparam int DramIdWidth   = 2;

  // Derived geometry
  localparam int LaneCount       = DramDataWidth / SocDataWidth;
  localparam int LaneSelWidth    = $clog2(LaneCount);
  localparam int LaneOffset      = $clog2(SocStrbWidth);
  localparam int WordOffsetWidth = $clog2(DramStrbWidth);
  localparam int DramIndexWidth  = $clog2(DramDepth);

  // Live remapped IDs, also the lane queue depth
  localparam int MaxOutstanding = 4;
  localparam int PtrWidth       = $clog2(MaxOutstanding);

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    CTRL_IDLE    = 2'd0,
    CTRL_ACCESS  = 2'd1,
    CTRL_RESPOND = 2'd2
  } ctrl_state_e;

endpackage

// ==== dram_req_if.sv ====
/* Request channel between subsystem blocks
   Single-beat valid/ready request with wide data and byte strobes */

`timescale 1ns/1ps

interface dram_req_if;

  logic                                valid;
  logic                                ready;
  dram_pkg::mem_op_e                   op;
  logic [dram_pkg::SocAddrWidth-1:0]   addr;
  logic [dram_pkg::DramIdWidth-1:0]    id;
  // Side field, full SoC ID ahead of the remap stage
  logic [dram_pkg::SocIdWidth-1:0]     soc_id;
  logic [dram_pkg::DramDataWidth-1:0]  data;
  logic [dram_pkg::DramStrbWidth-1:0]  strb;

  modport mgr (
    output valid, op, addr, id, soc_id, data, strb,
    input  ready
  );

  modport sub (
    input  valid, op, addr, id, soc_id, data, strb,
    output ready
  );

endinterface

// ==== dram_rsp_if.sv ====
/* Response channel between subsystem blocks
   Single-beat valid/ready response with wide data and error flag */

`timescale 1ns/1ps

interface dram_rsp_if;

  logic                                valid;
  logic                                ready;
  logic [dram_pkg::DramIdWidth-1:0]    id;
  // Restored SoC ID on the way back up
  logic [dram_pkg::SocIdWidth-1:0]     soc_id;
  logic [dram_pkg::DramDataWidth-1:0]  data;
  logic                                err;

  modport mgr (
    output valid, id, soc_id, data, err,
    input  ready
  );

  modport sub (
    input  valid, id, soc_id, data, err,
    output ready
  );

endinterface

// ==== dram_dw_upsizer.sv ====
/* Data width upsizer, 32-bit SoC bus onto 128-bit memory words
   Steers write lanes by address and selects the read lane from a queue */

`timescale 1ns/1ps

module dram_dw_upsizer (
  input  logic                                soc_clk_i,
  input  logic                                rst_n_i,
  // Narrow request
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic                                req_write_i,
  input  logic [dram_pkg::SocAddrWidth-1:0]   req_addr_i,
  input  logic [dram_pkg::SocIdWidth-1:0]     req_id_i,
  input  logic [dram_pkg::SocDataWidth-1:0]   req_wdata_i,
  input  logic [dram_pkg::SocStrbWidth-1:0]   req_strb_i,
  // Narrow response
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i,
  output logic [dram_pkg::SocIdWidth-1:0]     rsp_id_o,
  output logic [dram_pkg::SocDataWidth-1:0]   rsp_rdata_o,
  output logic                                rsp_err_o,
  // Wide side
  dram_req_if.mgr                             dn_req,
  dram_rsp_if.sub                             dn_rsp
);

  logic [dram_pkg::LaneSelWidth-1:0] req_lane;
  logic [dram_pkg::LaneSelWidth-1:0] head_lane;
  logic [dram_pkg::LaneSelWidth-1:0] lane_q [dram_pkg::MaxOutstanding];
  logic [dram_pkg::PtrWidth-1:0]     wr_ptr_q;
  logic [dram_pkg::PtrWidth-1:0]     rd_ptr_q;
  logic [dram_pkg::PtrWidth:0]       count_q;
  logic                              push;
  logic                              pop;
  logic                              q_full;
  logic                              q_empty;

  // Lane picked by address bits 3:2
  assign req_lane = req_addr_i[dram_pkg::LaneOffset +: dram_pkg::LaneSelWidth];

  //////////////////////////////
  // Request path
  //////////////////////////////
  assign dn_req.valid  = req_valid_i;
  assign req_ready_o   = dn_req.ready;
  assign dn_req.op     = req_write_i ? dram_pkg::OP_WRITE : dram_pkg::OP_READ;
  assign dn_req.addr   = req_addr_i;
  // Filled in by the remap stage
  assign dn_req.id     = '0;
  assign dn_req.soc_id = req_id_i;
  assign dn_req.data   = {dram_pkg::LaneCount{req_wdata_i}};

  always_comb begin
    for (int l = 0; l < dram_pkg::LaneCount; l++) begin
      dn_req.strb[l*dram_pkg::SocStrbWidth +: dram_pkg::SocStrbWidth] =
        (req_lane == l) ? req_strb_i : '0;
    end
  end

  //////////////////////////////
  // Lane queue
  //////////////////////////////
  assign push    = dn_req.valid && dn_req.ready;
  assign pop     = dn_rsp.valid && dn_rsp.ready;
  assign q_full  = (count_q == dram_pkg::MaxOutstanding);
  assign q_empty = (count_q == '0);

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (push) lane_q[wr_ptr_q] <= req_lane;
  end

  //////////////////////////////
  // Response path
  //////////////////////////////
  assign head_lane    = lane_q[rd_ptr_q];
  assign rsp_valid_o  = dn_rsp.valid;
  assign dn_rsp.ready = rsp_ready_i;
  assign rsp_id_o     = dn_rsp.soc_id;
  assign rsp_err_o    = dn_rsp.err;
  assign rsp_rdata_o  = dn_rsp.data[head_lane*dram_pkg::SocDataWidth +: dram_pkg::SocDataWidth];

  // Remap stage caps outstanding requests at the queue depth
  assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    !(push && q_full) && !(pop && q_empty))
    else $error("lane queue overflow or underflow");

endmodule

// ==== dram_iw_remap.sv ====
/* ID width remapper, 4-bit SoC IDs onto a small table of 2-bit memory IDs
   Allocates the lowest free entry per request and restores the ID on response */

`timescale 1ns/1ps

module dram_iw_remap (
  input  logic    soc_clk_i,
  input  logic    rst_n_i,
  dram_req_if.sub up_req,
  dram_rsp_if.mgr up_rsp,
  dram_req_if.mgr dn_req,
  dram_rsp_if.sub dn_rsp
);

  logic [dram_pkg::MaxOutstanding-1:0] tbl_valid_q;
  logic [dram_pkg::SocIdWidth-1:0]     tbl_id_q [dram_pkg::MaxOutstanding];
  logic [dram_pkg::DramIdWidth-1:0]    free_idx;
  logic [dram_pkg::DramIdWidth-1:0]    alloc_idx;
  logic [dram_pkg::DramIdWidth-1:0]    pend_idx_q;
  logic                                pend_q;
  logic                                tbl_full;
  logic                                req_fire;
  logic                                rsp_fire;

  //////////////////////////////
  // Allocation
  //////////////////////////////
  always_comb begin
    free_idx = '0;
    for (int i = dram_pkg::MaxOutstanding - 1; i >= 0; i--) begin
      if (!tbl_valid_q[i]) free_idx = dram_pkg::DramIdWidth'(i);
    end
  end

  assign tbl_full = &tbl_valid_q;

  // A stalled request keeps its entry, even if a lower one frees up meanwhile
  assign alloc_idx = pend_q ? pend_idx_q : free_idx;

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= dn_req.valid && !dn_req.ready;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    pend_idx_q <= alloc_idx;
  end

  //////////////////////////////
  // Request path
  //////////////////////////////
  assign dn_req.valid  = up_req.valid && !tbl_full;
  assign up_req.ready  = dn_req.ready && !tbl_full;
  assign dn_req.op     = up_req.op;
  assign dn_req.addr   = up_req.addr;
  assign dn_req.id     = alloc_idx;
  // SoC ID stays behind in the table
  assign dn_req.soc_id = '0;
  assign dn_req.data   = up_req.data;
  assign dn_req.strb   = up_req.strb;

  assign req_fire = dn_req.valid && dn_req.ready;
  assign rsp_fire = dn_rsp.valid && dn_rsp.ready;

  //////////////////////////////
  // ID table
  //////////////////////////////
  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tbl_valid_q <= '0;
    end else begin
      if (req_fire) tbl_valid_q[alloc_idx] <= 1'b1;
      if (rsp_fire) tbl_valid_q[dn_rsp.id] <= 1'b0;
    end
  end

  always_ff @(posedge soc_clk_i) begin
    if (req_fire) tbl_id_q[alloc_idx] <= up_req.soc_id;
  end

  // Response path
  assign up_rsp.valid  = dn_rsp.valid;
  assign dn_rsp.ready  = up_rsp.ready;
  assign up_rsp.id     = dn_rsp.id;
  assign up_rsp.soc_id = tbl_id_q[dn_rsp.id];
  assign up_rsp.data   = dn_rsp.data;
  assign up_rsp.err    = dn_rsp.err;

  // Controller only answers IDs handed out here
  assert property (@(posedge soc_clk_i) disable iff (!rst_n_i)
    dn_rsp.valid |-> tbl_valid_q[dn_rsp.id])
    else $error("response names unused ID %0d", dn_rsp.id);

endmodule

// ==== dram_ctrl.sv ====
/* Memory controller FSM
   Range-checks and trims addresses, runs one access, then holds the response */

`timescale 1ns/1ps

module dram_ctrl (
  input  logic                                  soc_clk_i,
  input  logic                                  rst_n_i,
  dram_req_if.sub                               req,
  dram_rsp_if.mgr                               rsp,
  output logic                                  mem_en_o,
  output logic                                  mem_we_o,
  output logic [dram_pkg::DramIndexWidth-1:0]   mem_index_o,
  output logic [dram_pkg::DramDataWidth-1:0]    mem_wdata_o,
  output logic [dram_pkg::DramStrbWidth-1:0]    mem_strb_o,
  input  logic [dram_pkg::DramDataWidth-1:0]    mem_rdata_i
);

  dram_pkg::ctrl_state_e               state_q;
  dram_pkg::ctrl_state_e               state_d;
  dram_pkg::mem_op_e                   op_q;
  logic [dram_pkg::DramIndexWidth-1:0] index_q;
  logic [dram_pkg::DramDataWidth-1:0]  data_q;
  logic [dram_pkg::DramStrbWidth-1:0]  strb_q;
  logic [dram_pkg::DramIdWidth-1:0]    id_q;
  logic                                in_range_q;
  logic                                in_range;
  logic                                req_fire;

  // Nothing may be set above the 4 KiB window
  assign in_range = ~|req.addr[dram_pkg::SocAddrWidth-1:dram_pkg::DramAddrWidth];
  assign req_fire = req.valid && req.ready;

  //////////////////////////////
  // FSM
  //////////////////////////////
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      dram_pkg::CTRL_IDLE:    if (req_fire) state_d = dram_pkg::CTRL_ACCESS;
      dram_pkg::CTRL_ACCESS:  state_d = dram_pkg::CTRL_RESPOND;
      dram_pkg::CTRL_RESPOND: if (rsp.ready) state_d = dram_pkg::CTRL_IDLE;
      default:                state_d = dram_pkg::CTRL_IDLE;
    endcase
  end

  always_ff @(posedge soc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= dram_pkg::CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request capture
  always_ff @(posedge soc_clk_i) begin
    if (req_fire) begin
      op_q       <= req.op;
      index_q    <= req.addr[dram_pkg::WordOffsetWidth +: dram_pkg::DramIndexWidth];
      data_q     <= req.data;
      strb_q     <= req.strb;
      id_q       <= req.id;
      in_range_q <= in_range;
    end
  end

  assign req.ready = (state_q == dram_pkg::CTRL_IDLE);

  //////////////////////////////
  // Memory port
  //////////////////////////////
  assign mem_en_o    = (state_q == dram_pkg::CTRL_ACCESS) && in_range_q;
  assign mem_we_o    = (op_q == dram_pkg::OP_WRITE);
  assign mem_index_o = index_q;
  assign mem_wdata_o = data_q;
  assign mem_strb_o  = strb_q;

  // Response, read data stays on the array output until the next access
  assign rsp.valid  = (state_q == dram_pkg::CTRL_RESPOND);
  assign rsp.id     = id_q;
  assign rsp.soc_id = '0;
  assign rsp.err    = !in_range_q;
  assign rsp.data   = (in_range_q && op_q == dram_pkg::OP_READ) ? mem_rdata_i : '0;

endmodule

// ==== dram_array.sv ====
/* Behavioral wide memory in place of the DRAM controller
   Byte-strobed writes and a registered read port */

`timescale 1ns/1ps

module dram_array (
  input  logic                                  soc_clk_i,
  input  logic                                  mem_en_i,
  input  logic                                  mem_we_i,
  input  logic [dram_pkg::DramIndexWidth-1:0]   mem_index_i,
  input  logic [dram_pkg::DramDataWidth-1:0]    mem_wdata_i,
  input  logic [dram_pkg::DramStrbWidth-1:0]    mem_strb_i,
  output logic [dram_pkg::DramDataWidth-1:0]    mem_rdata_o
);

  logic [dram_pkg::DramDataWidth-1:0] mem_q [dram_pkg::DramDepth];

  // Write under strobes
  always_ff @(posedge soc_clk_i) begin
    if (mem_en_i && mem_we_i) begin
      for (int b = 0; b < dram_pkg::DramStrbWidth; b++) begin
        if (mem_strb_i[b]) mem_q[mem_index_i][b*8 +: 8] <= mem_wdata_i[b*8 +: 8];
      end
    end
  end

  // Read port, output held between reads
  always_ff @(posedge soc_clk_i) begin
    if (mem_en_i && !mem_we_i) begin
      mem_rdata_o <= mem_q[mem_index_i];
    end
  end

endmodule

// ==== dram_wrapper.sv ====
/* Memory subsystem top level
   Chains upsizer, ID remap, controller and wide memory behind a 32-bit SoC port */

`timescale 1ns/1ps

module dram_wrapper (
  input  logic                                soc_clk_i,
  input  logic                                rst_n_i,
  // SoC request
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  logic                                req_write_i,
  input  logic [dram_pkg::SocAddrWidth-1:0]   req_addr_i,
  input  logic [dram_pkg::SocIdWidth-1:0]     req_id_i,
  input  logic [dram_pkg::SocDataWidth-1:0]   req_wdata_i,
  input  logic [dram_pkg::SocStrbWidth-1:0]   req_strb_i,
  // SoC response
  output logic                                rsp_valid_o,
  input  logic                                rsp_ready_i,
  output logic [dram_pkg::SocIdWidth-1:0]     rsp_id_o,
  output logic [dram_pkg::SocDataWidth-1:0]   rsp_rdata_o,
  output logic                                rsp_err_o
);

  // Between upsizer and remap
  dram_req_if up_req ();
  dram_rsp_if up_rsp ();

  // Between remap and controller
  dram_req_if dn_req ();
  dram_rsp_if dn_rsp ();

  // Memory port
  logic                                mem_en;
  logic                                mem_we;
  logic [dram_pkg::DramIndexWidth-1:0] mem_index;
  logic [dram_pkg::DramDataWidth-1:0]  mem_wdata;
  logic [dram_pkg::DramStrbWidth-1:0]  mem_strb;
  logic [dram_pkg::DramDataWidth-1:0]  mem_rdata;

  //////////////////////////////
  // Width and ID resizing
  //////////////////////////////
  dram_dw_upsizer u_upsizer (
    .soc_clk_i   ( soc_clk_i   ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_write_i ( req_write_i ),
    .req_addr_i  ( req_addr_i  ),
    .req_id_i    ( req_id_i    ),
    .req_wdata_i ( req_wdata_i ),
    .req_strb_i  ( req_strb_i  ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_id_o    ( rsp_id_o    ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .dn_req      ( up_req      ),
    .dn_rsp      ( up_rsp      )
  );

  dram_iw_remap u_remap (
    .soc_clk_i ( soc_clk_i ),
    .rst_n_i   ( rst_n_i   ),
    .up_req    ( up_req    ),
    .up_rsp    ( up_rsp    ),
    .dn_req    ( dn_req    ),
    .dn_rsp    ( dn_rsp    )
  );

  //////////////////////////////
  // Controller and memory
  //////////////////////////////
  dram_ctrl u_ctrl (
    .soc_clk_i   ( soc_clk_i ),
    .rst_n_i     ( rst_n_i   ),
    .req         ( dn_req    ),
    .rsp         ( dn_rsp    ),
    .mem_en_o    ( mem_en    ),
    .mem_we_o    ( mem_we    ),
    .mem_index_o ( mem_index ),
    .mem_wdata_o ( mem_wdata ),
    .mem_strb_o  ( mem_strb  ),
    .mem_rdata_i ( mem_rdata )
  );

  dram_array u_array (
    .soc_clk_i   ( soc_clk_i ),
    .mem_en_i    ( mem_en    ),
    .mem_we_i    ( mem_we    ),
    .mem_index_i ( mem_index ),
    .mem_wdata_i ( mem_wdata ),
    .mem_strb_i  ( mem_strb  ),
    .mem_rdata_o ( mem_rdata )
  );

endmodule

// ==== dram_checker.sv ====
/* Response checker for the memory subsystem
   Byte-level memory model and in-order comparison of every response */

`timescale 1ns/1ps

module dram_checker (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                req_valid_i,
  input  logic                                req_ready_i,
  input  logic                                req_write_i,
  input  logic [dram_pkg::SocAddrWidth-1:0]   req_addr_i,
  input  logic [dram_pkg::SocIdWidth-1:0]     req_id_i,
  input  logic [dram_pkg::SocDataWidth-1:0]   req_wdata_i,
  input  logic [dram_pkg::SocStrbWidth-1:0]   req_strb_i,
  input  logic                                rsp_valid_i,
  input  logic                                rsp_ready_i,
  input  logic [dram_pkg::SocIdWidth-1:0]     rsp_id_i,
  input  logic [dram_pkg::SocDataWidth-1:0]   rsp_rdata_i,
  input  logic                                rsp_err_i,
  output int                                  err_count_o,
  output int                                  rsp_count_o,
  output int                                  pending_o
);

  logic [7:0]                        mem_model [1 << dram_pkg::DramAddrWidth];
  logic [dram_pkg::SocIdWidth-1:0]   exp_id_q [$];
  logic [dram_pkg::SocDataWidth-1:0] exp_data_q [$];
  logic                              exp_err_q [$];
  logic [dram_pkg::SocIdWidth-1:0]   exp_id;
  logic [dram_pkg::SocDataWidth-1:0] exp_data;
  logic                              exp_err;
  // Payload seen while the response was stalled
  logic                              hold;
  logic [dram_pkg::SocIdWidth-1:0]   hold_id;
  logic [dram_pkg::SocDataWidth-1:0] hold_data;
  logic                              hold_err;
  int                                err_count = 0;
  int                                rsp_count = 0;
  int                                pending   = 0;

  assign err_count_o = err_count;
  assign rsp_count_o = rsp_count;
  assign pending_o   = pending;

  initial begin
    hold = 1'b0;
    for (int i = 0; i < (1 << dram_pkg::DramAddrWidth); i++) begin
      mem_model[i] = 8'h00;
    end
  end

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0d ns: %s expected %h got %h", $time, name, expected, actual);
      err_count++;
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  task automatic accept_req();
    logic [dram_pkg::DramAddrWidth-1:0] base;
    logic [dram_pkg::SocDataWidth-1:0]  rdata;
    base  = {req_addr_i[dram_pkg::DramAddrWidth-1:2], 2'b00};
    rdata = '0;
    exp_id_q.push_back(req_id_i);
    if (|req_addr_i[dram_pkg::SocAddrWidth-1:dram_pkg::DramAddrWidth]) begin
      exp_data_q.push_back('0);
      exp_err_q.push_back(1'b1);
    end else begin
      for (int b = 0; b < dram_pkg::SocStrbWidth; b++) begin
        if (req_write_i && req_strb_i[b]) mem_model[base + b] = req_wdata_i[b*8 +: 8];
        rdata[b*8 +: 8] = mem_model[base + b];
      end
      exp_data_q.push_back(req_write_i ? '0 : rdata);
      exp_err_q.push_back(1'b0);
    end
  endtask

  //////////////////////////////
  // Response monitor
  //////////////////////////////
  always @(posedge clk_i) begin
    if (rst_n_i) begin
      if (hold) begin
        if (!rsp_valid_i) begin
          $display("ERROR at %0d ns: rsp_valid_o dropped before the response was taken", $time);
          err_count++;
        end else begin
          compare_field("rsp_id_o while stalled", hold_id, rsp_id_i);
          compare_field("rsp_rdata_o while stalled", hold_data, rsp_rdata_i);
          compare_field("rsp_err_o while stalled", hold_err, rsp_err_i);
        end
      end
      if (rsp_valid_i && rsp_ready_i) begin
        rsp_count++;
        if (exp_err_q.size() == 0) begin
          $display("ERROR at %0d ns: response arrived with no request outstanding", $time);
          err_count++;
        end else begin
          exp_id   = exp_id_q.pop_front();
          exp_data = exp_data_q.pop_front();
          exp_err  = exp_err_q.pop_front();
          compare_field("rsp_id_o", exp_id, rsp_id_i);
          compare_field("rsp_rdata_o", exp_data, rsp_rdata_i);
          compare_field("rsp_err_o", exp_err, rsp_err_i);
        end
      end
      if (req_valid_i && req_ready_i) accept_req();
      hold      = rsp_valid_i && !rsp_ready_i;
      hold_id   = rsp_id_i;
      hold_data = rsp_rdata_i;
      hold_err  = rsp_err_i;
      pending   = exp_err_q.size();
    end
  end

endmodule

// ==== tb_dram_wrapper.sv ====
/* Testbench for the memory subsystem
   Random single-beat traffic with optional response back-pressure */

`timescale 1ns/1ps

module tb_dram_wrapper;

  localparam int Timeout = 200;

  logic        soc_clk = 1'b0;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  logic        req_write;
  logic [31:0] req_addr;
  logic [3:0]  req_id;
  logic [31:0] req_wdata;
  logic [3:0]  req_strb;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [3:0]  rsp_id;
  logic [31:0] rsp_rdata;
  logic        rsp_err;
  int          chk_errors;
  int          rsp_checked;
  int          pending;
  integer      seed = 32'hbad4;
  int          tb_errors = 0;
  int          tests_run = 0;
  int          bp_left = 0;
  logic        bp_on = 1'b0;
  logic        hung = 1'b0;

  always #4 soc_clk = ~soc_clk;

  dram_wrapper u_dram_wrapper (
    .soc_clk_i (soc_clk),   .rst_n_i (rst_n),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_write_i (req_write),
    .req_addr_i (req_addr), .req_id_i (req_id), .req_wdata_i (req_wdata),
    .req_strb_i (req_strb), .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready),
    .rsp_id_o (rsp_id), .rsp_rdata_o (rsp_rdata), .rsp_err_o (rsp_err)
  );

  dram_checker u_checker (
    .clk_i (soc_clk), .rst_n_i (rst_n),
    .req_valid_i (req_valid), .req_ready_i (req_ready), .req_write_i (req_write),
    .req_addr_i (req_addr), .req_id_i (req_id), .req_wdata_i (req_wdata),
    .req_strb_i (req_strb), .rsp_valid_i (rsp_valid), .rsp_ready_i (rsp_ready),
    .rsp_id_i (rsp_id), .rsp_rdata_i (rsp_rdata), .rsp_err_i (rsp_err),
    .err_count_o (chk_errors), .rsp_count_o (rsp_checked), .pending_o (pending)
  );

  //////////////////////////////
  // Cycle and handshake helpers
  //////////////////////////////
  // Rising edge, plus random stall stretches on the response side
  task automatic tick();
    logic [31:0] r;
    @(posedge soc_clk);
    if (bp_on && bp_left == 0) begin
      r = $random(seed);
      rsp_ready <= r[0];
      bp_left = int'(r[6:4]) + 1;
    end else if (bp_on) begin
      bp_left--;
    end else begin
      rsp_ready <= 1'b1;
    end
  endtask

  task automatic send_req(input logic write, input logic [31:0] addr, input logic [3:0] id,
                          input logic [31:0] wdata, input logic [3:0] strb);
    int   waited;
    logic taken;
    if (hung) return;
    req_valid <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_id    <= id;
    req_wdata <= wdata;
    req_strb  <= strb;
    waited = 0;
    taken  = 1'b0;
    while (!taken && waited < Timeout) begin
      @(negedge soc_clk);
      taken = req_ready;
      tick();
      waited++;
    end
    req_valid <= 1'b0;
    if (!taken) begin
      $display("TIMEOUT at %0d ns: request to address %h was never accepted", $time, addr);
      hung = 1'b1;
    end
  endtask

  task automatic wait_idle(input string what);
    int   waited;
    logic idle;
    if (hung) return;
    waited = 0;
    idle   = 1'b0;
    while (!idle && waited < Timeout) begin
      @(negedge soc_clk);
      idle = (pending == 0);
      tick();
      waited++;
    end
    if (!idle) begin
      $display("TIMEOUT at %0d ns: %0d responses never arrived in %s", $time, pending, what);
      hung = 1'b1;
    end
  endtask

  task automatic end_test(input string name);
    wait_idle(name);
    tests_run++;
    $display("test %s done, %0d responses checked, %0d errors so far",
             name, rsp_checked, chk_errors + tb_errors);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  task automatic check_reset();
    @(negedge soc_clk);
    if (rsp_valid !== 1'b0) begin
      $display("CHECK FAILED at %0d ns: rsp_valid_o expected 0 got %b", $time, rsp_valid);
      tb_errors++;
    end
    if (req_ready !== 1'b1) begin
      $display("CHECK FAILED at %0d ns: req_ready_o expected 1 got %b", $time, req_ready);
      tb_errors++;
    end
    tick();
  endtask

  task automatic write_then_read(input int n);
    logic [31:0] r;
    logic [31:0] d;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      d = $random(seed);
      send_req(1'b1, {20'b0, r[11:2], 2'b00}, r[15:12], d, 4'hf);
      send_req(1'b0, {20'b0, r[11:2], 2'b00}, r[19:16], 32'h0, 4'h0);
    end
  endtask

  task automatic partial_lanes(input int n);
    logic [31:0] r;
    logic [31:0] d;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      d = $random(seed);
      send_req(1'b1, {20'b0, r[11:2], 2'b00}, r[15:12], d, r[19:16]);
      for (int l = 0; l < dram_pkg::LaneCount; l++) begin
        send_req(1'b0, {20'b0, r[11:4], 4'b0} | (l << 2), r[23:20], 32'h0, 4'h0);
      end
    end
  endtask

  // Mixed reads and writes, some above the 4 KiB window when oor is set
  task automatic mixed_traffic(input int n, input logic oor);
    logic [31:0] r;
    logic [31:0] d;
    logic [31:0] a;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      d = $random(seed);
      a = {20'b0, r[11:0]};
      if (oor && r[31:29] == 3'b000) a[dram_pkg::DramAddrWidth + (r[28:24] % 20)] = 1'b1;
      send_req(r[12], a, r[16:13], d, r[20:17]);
    end
  endtask

  task automatic out_of_range(input int n);
    logic [31:0] r;
    logic [31:0] a;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      a = $random(seed);
      if (a[31:dram_pkg::DramAddrWidth] == '0) a[31] = 1'b1;
      send_req(r[0], a, r[4:1], $random(seed), 4'hf);
      send_req(1'b0, {20'b0, a[11:0]}, r[8:5], 32'h0, 4'h0);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_id    = '0;
    req_wdata = '0;
    req_strb  = '0;
    rsp_ready = 1'b1;
    repeat (8) @(posedge soc_clk);
    rst_n <= 1'b1;
    check_reset();
    end_test("reset");
    // Known contents before any read
    for (int a = 0; a < (1 << dram_pkg::DramAddrWidth); a += 4) begin
      send_req(1'b1, a, a[5:2], 32'h0, 4'hf);
    end
    end_test("clear");
    write_then_read(16);
    end_test("write_read");
    partial_lanes(16);
    end_test("partial");
    mixed_traffic(200, 1'b0);
    end_test("mixed");
    out_of_range(16);
    end_test("range");
    bp_on = 1'b1;
    mixed_traffic(200, 1'b1);
    end_test("backpressure");
    bp_on = 1'b0;
    @(negedge soc_clk);
    $display("tests run %0d, responses checked %0d, errors %0d, timeouts %0d",
             tests_run, rsp_checked, chk_errors + tb_errors, hung);
    if (chk_errors + tb_errors == 0 && !hung) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== dram_wrapper.f ====
dram_pkg.sv
dram_req_if.sv
dram_rsp_if.sv
dram_dw_upsizer.sv
dram_iw_remap.sv
dram_ctrl.sv
dram_array.sv
dram_wrapper.sv
dram_checker.sv
tb_dram_wrapper.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dram_wrapper \
  -f dram_wrapper.f -o sim_dram_wrapper > build.log 2>&1 \
  && ./obj_dir/sim_dram_wrapper > sim.log 2>&1 \
  || { echo "build or run failed"; cat build.log; }

cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log 2>/dev/null && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
